/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_axi_axil_rd_adapter
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator status is ignored here, the log search below decides the result
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/axi_axil_rd_properties.sv */
// concurrent handshake checks on the read adapter, attached to its top level by bind
`timescale 1ns/1ps

module axi_axil_rd_properties
    import axi_types_pkg::*;
    import adapter_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         arready,
    input logic         rvalid,
    input logic         rready,
    input data_t        rdata,
    input logic         rlast,
    input logic         m_arvalid,
    input logic         m_arready,
    input addr_t        m_araddr,
    input burst_state_t burst_state
);

    // a held beat must not change under back-pressure
    rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
        else $error("rvalid dropped or its beat changed before rready");

    m_arvalid_hold: assert property (@(posedge clk) disable iff (rst)
        m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
        else $error("m_arvalid dropped or m_araddr changed before m_arready");

    arready_in_burst: assert property (@(posedge clk) disable iff (rst)
        burst_state == BURST_DATA |-> !arready)
        else $error("arready high while a burst is in progress");

endmodule

bind axi_axil_rd_adapter axi_axil_rd_properties props_i (
    .clk         (clk),
    .rst         (rst),
    .arready     (arready),
    .rvalid      (rvalid),
    .rready      (rready),
    .rdata       (rdata),
    .rlast       (rlast),
    .m_arvalid   (m_arvalid),
    .m_arready   (m_arready),
    .m_araddr    (m_araddr),
    .burst_state (burst_ctrl_i.state_reg)
);

/* dv/tb_axi_axil_rd_adapter.sv */
// directed testbench for the AXI4 to AXI4-Lite read adapter, with a random-latency Lite slave model
`timescale 1ns/1ps

module tb_axi_axil_rd_adapter;
    import axi_types_pkg::*;

    logic clk;
    logic rst;
    logic arvalid;
    logic arready;
    id_t arid;
    addr_t araddr;
    len_t arlen;
    size_t arsize;
    prot_t arprot;
    id_t rid;
    data_t rdata;
    resp_t rresp;
    logic rlast;
    logic rvalid;
    logic rready;
    addr_t m_araddr;
    prot_t m_arprot;
    logic m_arvalid;
    logic m_arready;
    data_t m_rdata;
    resp_t m_rresp;
    logic m_rvalid;
    logic m_rready;

    // Lite addresses and prot seen by the slave model, and the beats accepted on the AXI side
    addr_t lite_log[$];
    prot_t prot_log[$];
    data_t got_data[$];
    resp_t got_resp[$];
    id_t got_id[$];
    logic got_last[$];
    logic bp_enable;

    axi_axil_rd_adapter dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        report_failure($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_resp(input string name, input resp_t got, input resp_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_prot(input string name, input prot_t got, input prot_t exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    // the Lite slave errors when address bits 15:12 are all ones
    function automatic resp_t expected_resp(input addr_t addr);
        return (addr[15:12] == 4'hf) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    initial begin : lite_slave
        addr_t pend_q[$];
        addr_t a;
        logic r_fire;
        m_arready = 1'b0;
        m_rvalid = 1'b0;
        m_rdata = '0;
        m_rresp = RESP_OKAY;
        r_fire = 1'b0;
        forever begin
            @(negedge clk);
            if (r_fire) begin
                m_rvalid = 1'b0;
                r_fire = 1'b0;
            end
            if (!m_rvalid && pend_q.size() > 0 && ($urandom % 3) == 0) begin
                a = pend_q.pop_front();
                m_rvalid = 1'b1;
                m_rdata = a ^ 32'hA5A5_0000;
                m_rresp = expected_resp(a);
            end
            // both handshakes complete at the coming rising edge
            r_fire = m_rvalid && m_rready;
            m_arready = ($urandom % 4) != 0;
            if (m_arvalid && m_arready) begin
                pend_q.push_back(m_araddr);
                lite_log.push_back(m_araddr);
                prot_log.push_back(m_arprot);
            end
        end
    end

    initial begin : r_sink
        rready = 1'b0;
        forever begin
            @(negedge clk);
            rready = bp_enable ? (($urandom % 2) == 0) : 1'b1;
            if (rvalid && rready) begin
                got_data.push_back(rdata);
                got_resp.push_back(rresp);
                got_id.push_back(rid);
                got_last.push_back(rlast);
            end
        end
    end

    task automatic test_reset_values();
        int cycles;
        cycles = 0;
        while (arready !== 1'b1) begin
            check_bit("rvalid", rvalid, 1'b0);
            check_bit("m_arvalid", m_arvalid, 1'b0);
            check_bit("m_rready", m_rready, 1'b0);
            @(negedge clk);
            cycles++;
            if (cycles > 10) report_failure("timeout: arready did not rise after reset");
        end
        check_bit("rvalid", rvalid, 1'b0);
        check_bit("m_arvalid", m_arvalid, 1'b0);
        check_bit("m_rready", m_rready, 1'b0);
    endtask

    // one AXI burst, then every Lite address and every beat against the slave rules
    task automatic run_burst(input id_t id, input addr_t addr, input len_t len,
                             input size_t size, input logic bp);
        int n;
        int cycles;
        addr_t exp_addr;
        n = int'(len) + 1;
        lite_log.delete();
        prot_log.delete();
        got_data.delete();
        got_resp.delete();
        got_id.delete();
        got_last.delete();
        bp_enable = bp;
        arvalid = 1'b1;
        arid = id;
        araddr = addr;
        arlen = len;
        arsize = size;
        arprot = prot_t'(id);
        cycles = 0;
        while (!arready) begin
            @(negedge clk);
            cycles++;
            if (cycles > 50) report_failure("timeout: the burst address was never accepted");
        end
        @(negedge clk);
        arvalid = 1'b0;
        // the burst fields must have been captured at the handshake
        arid = ~id;
        araddr = ~addr;
        arlen = ~len;
        arsize = ~size;
        arprot = ~prot_t'(id);
        cycles = 0;
        while (got_data.size() < n) begin
            if (arready && !(rvalid && rlast) && !(got_last.size() > 0 && got_last[$]))
                report_failure("arready rose before the last beat reached the R channel");
            @(negedge clk);
            cycles++;
            if (cycles > 200 * n)
                report_failure($sformatf("timeout: %0d of %0d beats", got_data.size(), n));
        end
        // room for a stray extra beat or Lite read to show up
        repeat (5) @(negedge clk);
        bp_enable = 1'b0;
        if (got_data.size() != n || lite_log.size() != n)
            report_failure($sformatf("expected %0d beats and Lite reads, saw %0d and %0d",
                                     n, got_data.size(), lite_log.size()));
        for (int i = 0; i < n; i++) begin
            exp_addr = addr + (addr_t'(i) << size);
            check_addr($sformatf("m_araddr[%0d]", i), lite_log[i], exp_addr);
            check_prot($sformatf("m_arprot[%0d]", i), prot_log[i], prot_t'(id));
            check_data($sformatf("rdata[%0d]", i), got_data[i], exp_addr ^ 32'hA5A5_0000);
            check_resp($sformatf("rresp[%0d]", i), got_resp[i], expected_resp(exp_addr));
            check_id($sformatf("rid[%0d]", i), got_id[i], id);
            check_bit($sformatf("rlast[%0d]", i), got_last[i], i == n - 1);
        end
    endtask

    initial begin
        void'($urandom(32'h76b4));
        bp_enable = 1'b0;
        rst = 1'b1;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        arprot = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset_values();
        run_burst(4'h3, 32'h0000_0100, 8'd0, 3'd2, 1'b0);
        run_burst(4'ha, 32'h0000_2000, 8'd7, 3'd2, 1'b0);
        // narrow beats from an odd address
        run_burst(4'h6, 32'h0000_1003, 8'd5, 3'd0, 1'b0);
        // crosses from 0xeffc into the error region at 0xf000
        run_burst(4'hc, 32'h0000_eff8, 8'd3, 3'd2, 1'b0);
        run_burst(4'h5, 32'h0000_4040, 8'd15, 3'd2, 1'b1);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* hdl/adapter_pkg.sv */
// internal adapter types, shared by the burst control and the bound assertions
package adapter_pkg;

    // one burst in flight at a time, so two states suffice
    typedef enum logic [0:0] {
        BURST_IDLE,
        BURST_DATA
    } burst_state_t;

endpackage

/* hdl/axi_axil_rd_adapter.sv */
// AXI4 to AXI4-Lite read adapter top level, equal 32-bit widths, one burst in flight
`timescale 1ns/1ps

module axi_axil_rd_adapter
    import axi_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    // AXI4 read slave
    input  logic   arvalid,
    output logic   arready,
    input  id_t    arid,
    input  addr_t  araddr,
    input  len_t   arlen,
    input  size_t  arsize,
    input  prot_t  arprot,
    output id_t    rid,
    output data_t  rdata,
    output resp_t  rresp,
    output logic   rlast,
    output logic   rvalid,
    input  logic   rready,

    // AXI4-Lite read master
    output addr_t  m_araddr,
    output prot_t  m_arprot,
    output logic   m_arvalid,
    input  logic   m_arready,
    input  data_t  m_rdata,
    input  resp_t  m_rresp,
    input  logic   m_rvalid,
    output logic   m_rready
);

    lite_req_if req_if ();
    beat_if beat_bus ();

    axi_rd_burst_ctrl burst_ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arprot  (arprot),
        .req     (req_if.burst),
        .beat    (beat_bus.ctrl)
    );

    axil_ar_issue ar_issue_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req_if.issue),
        .m_araddr  (m_araddr),
        .m_arprot  (m_arprot),
        .m_arvalid (m_arvalid),
        .m_arready (m_arready)
    );

    axi_r_return r_return_i (
        .clk      (clk),
        .rst      (rst),
        .beat     (beat_bus.ret),
        .m_rdata  (m_rdata),
        .m_rresp  (m_rresp),
        .m_rvalid (m_rvalid),
        .m_rready (m_rready),
        .rid      (rid),
        .rdata    (rdata),
        .rresp    (rresp),
        .rlast    (rlast),
        .rvalid   (rvalid),
        .rready   (rready)
    );

endmodule

/* hdl/axi_r_return.sv */
// read return stage; turns each Lite read response into one buffered AXI R beat
`timescale 1ns/1ps

module axi_r_return
    import axi_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst,

    beat_if.ret    beat,

    input  data_t  m_rdata,
    input  resp_t  m_rresp,
    input  logic   m_rvalid,
    output logic   m_rready,

    output id_t    rid,
    output data_t  rdata,
    output resp_t  rresp,
    output logic   rlast,
    output logic   rvalid,
    input  logic   rready
);

    logic m_rready_reg;

    id_t rid_reg;
    data_t rdata_reg;
    resp_t rresp_reg;
    logic rlast_reg;
    logic rvalid_reg;

    assign beat.take = m_rready_reg && m_rvalid;

    assign m_rready = m_rready_reg;
    assign rid = rid_reg;
    assign rdata = rdata_reg;
    assign rresp = rresp_reg;
    assign rlast = rlast_reg;
    assign rvalid = rvalid_reg;

    always_ff @(posedge clk) begin
        // single beat buffer, so only accept a response while it is empty
        m_rready_reg <= beat.open && !rvalid_reg && !beat.take;
        rvalid_reg <= rvalid_reg && !rready;

        if (beat.take) begin
            rid_reg <= beat.id;
            rdata_reg <= m_rdata;
            rresp_reg <= m_rresp;
            rlast_reg <= beat.last;
            rvalid_reg <= 1'b1;
        end

        if (rst) begin
            m_rready_reg <= 1'b0;
            rvalid_reg <= 1'b0;
        end
    end

endmodule

/* hdl/axi_rd_burst_ctrl.sv */
// AXI read burst control; accepts one AR burst and counts Lite beats down to the last one
`timescale 1ns/1ps

module axi_rd_burst_ctrl
    import axi_types_pkg::*;
    import adapter_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  logic       arvalid,
    output logic       arready,
    input  id_t        arid,
    input  addr_t      araddr,
    input  len_t       arlen,
    input  size_t      arsize,
    input  prot_t      arprot,

    lite_req_if.burst  req,
    beat_if.ctrl       beat
);

    burst_state_t state_reg, state_next;

    len_t count_reg, count_next;
    id_t id_reg, id_next;

    logic arready_reg, arready_next;

    assign arready = arready_reg;

    // burst fields go straight to the issuer, which latches them on start
    assign req.addr = araddr;
    assign req.size = arsize;
    assign req.prot = arprot;

    assign beat.open = (state_reg == BURST_DATA) && !req.pending;
    assign beat.id = id_reg;
    assign beat.last = (count_reg == '0);

    always_comb begin
        state_next = state_reg;
        count_next = count_reg;
        id_next = id_reg;
        arready_next = 1'b0;
        req.start = 1'b0;
        req.next = 1'b0;

        case (state_reg)
            BURST_IDLE: begin
                // hold off new bursts until the last Lite address has gone out
                arready_next = !req.pending;

                if (arready_reg && arvalid) begin
                    arready_next = 1'b0;
                    id_next = arid;
                    count_next = arlen;
                    req.start = 1'b1;
                    state_next = BURST_DATA;
                end
            end
            BURST_DATA: begin
                if (beat.take) begin
                    count_next = count_reg - 1'b1;
                    if (count_reg == '0) begin
                        arready_next = !req.pending;
                        state_next = BURST_IDLE;
                    end else begin
                        req.next = 1'b1;
                    end
                end
            end
            default: begin
                state_next = BURST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        state_reg <= state_next;
        count_reg <= count_next;
        id_reg <= id_next;
        arready_reg <= arready_next;

        if (rst) begin
            state_reg <= BURST_IDLE;
            arready_reg <= 1'b0;
        end
    end

endmodule

/* hdl/axi_types_pkg.sv */
// AXI and AXI-Lite field widths and response codes, imported by the adapter RTL and its testbench
package axi_types_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W = 4;
    localparam int LEN_W = 8;
    localparam int SIZE_W = 3;
    localparam int PROT_W = 3;
    localparam int RESP_W = 2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0] id_t;
    typedef logic [LEN_W-1:0] len_t;
    typedef logic [SIZE_W-1:0] size_t;
    typedef logic [PROT_W-1:0] prot_t;
    typedef logic [RESP_W-1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* hdl/axil_ar_issue.sv */
// Lite read address issuer; holds the burst address and steps it by the beat size per request
`timescale 1ns/1ps

module axil_ar_issue
    import axi_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    lite_req_if.issue  req,

    output addr_t      m_araddr,
    output prot_t      m_arprot,
    output logic       m_arvalid,
    input  logic       m_arready
);

    addr_t addr_reg;
    size_t size_reg;
    prot_t prot_reg;
    logic arvalid_reg;

    // 2**size bytes per beat, independent of burst type
    addr_t step;

    assign step = addr_t'(1) << size_reg;

    assign m_araddr = addr_reg;
    assign m_arprot = prot_reg;
    assign m_arvalid = arvalid_reg;
    assign req.pending = arvalid_reg;

    always_ff @(posedge clk) begin
        if (req.start) begin
            addr_reg <= req.addr;
            size_reg <= req.size;
            prot_reg <= req.prot;
        end else if (req.next) begin
            addr_reg <= addr_reg + step;
        end

        arvalid_reg <= (arvalid_reg && !m_arready) || req.start || req.next;

        if (rst) begin
            arvalid_reg <= 1'b0;
        end
    end

endmodule

/* hdl/beat_if.sv */
// beat handoff between burst control and the read return stage
`timescale 1ns/1ps

interface beat_if
    import axi_types_pkg::*;
();

    logic open;
    id_t id;
    logic last;
    // one pulse per Lite read response accepted
    logic take;

    modport ctrl (output open, id, last, input take);
    modport ret (input open, id, last, output take);

endinterface

/* hdl/lite_req_if.sv */
// request path from burst control to the Lite address issuer; start loads a burst, next steps it
`timescale 1ns/1ps

interface lite_req_if
    import axi_types_pkg::*;
();

    logic start;
    logic next;
    addr_t addr;
    size_t size;
    prot_t prot;
    logic pending;

    modport burst (output start, next, addr, size, prot, input pending);
    modport issue (input start, next, addr, size, prot, output pending);

endinterface

/* src.f */
hdl/axi_types_pkg.sv
hdl/adapter_pkg.sv
hdl/lite_req_if.sv
hdl/beat_if.sv
hdl/axi_rd_burst_ctrl.sv
hdl/axil_ar_issue.sv
hdl/axi_r_return.sv
hdl/axi_axil_rd_adapter.sv
dv/axi_axil_rd_properties.sv
dv/tb_axi_axil_rd_adapter.sv
